/* src.f */
verilog/tron_pkg.sv
verilog/key_decode.sv
verilog/game_control.sv
verilog/cycle_mover.sv
verilog/trail_grid.sv
verilog/tron_top.sv
test/tb_tron.sv

/* Bender.yml */
package:
  name: tron

sources:
  - verilog/tron_pkg.sv
  - verilog/key_decode.sv
  - verilog/game_control.sv
  - verilog/cycle_mover.sv
  - verilog/trail_grid.sv
  - verilog/tron_top.sv
  - target: test
    files:
      - test/tb_tron.sv

/* test/tb_tron.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_tron;

	import tron_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int CLEAR_PIXELS = (int'(RIGHT_EDGE) - int'(LEFT_EDGE) + 1)
		* (int'(BOTTOM_EDGE) - int'(TOP_EDGE) + 1);
	localparam int PLOT_WAIT = FRAME_TICKS + 16;	// Longest gap between draw plots
	localparam int MAX_FRAMES = 120;
	localparam int CYCLE_LIMIT = 2 * (CLEAR_PIXELS + 64)
		+ MAX_FRAMES * (FRAME_TICKS + 8) + 4000;

	logic clk;
	logic resetn;
	logic [7:0] scan_code;
	logic scan_valid;
	logic scan_make;
	logic plot;
	x_t plot_x;
	y_t plot_y;
	colour_t plot_colour;
	score_t p1_score;
	score_t p2_score;

	// Reference model of the game
	x_t m1_x, m2_x;
	y_t m1_y, m2_y;
	heading_t m1_h, m2_h, m1_req, m2_req;
	score_t m1_score, m2_score;
	logic trail [FIELD_W][FIELD_H];
	logic [7:0] lfsr_state;
	int cycle_count = 0;

	tron_top tron_top_i (
		.clk(clk),
		.resetn(resetn),
		.scan_code(scan_code),
		.scan_valid(scan_valid),
		.scan_make(scan_make),
		.plot(plot),
		.plot_x(plot_x),
		.plot_y(plot_y),
		.plot_colour(plot_colour),
		.p1_score(p1_score),
		.p2_score(p2_score)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
			report_failure("simulation ran past its cycle limit, the DUT seems stuck");
	end

	task automatic report_failure(input string msg);
		$display("Verification failed");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_xy(input x_t got_x, input y_t got_y, input x_t exp_x, input y_t exp_y,
			input string what);
		if (got_x !== exp_x || got_y !== exp_y) begin
			$display("FAIL %0t: %s at (%0d,%0d), expected (%0d,%0d)", $time, what,
				got_x, got_y, exp_x, exp_y);
			report_failure("wrong pixel position");
		end
	endtask

	task automatic check_colour(input colour_t got, input colour_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
			report_failure("wrong pixel colour");
		end
	endtask

	task automatic check_score(input score_t got, input score_t exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
			report_failure("wrong score");
		end
	endtask

	// Fibonacci LFSR with taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic random_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr_state[7]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic heading_t reverse_of(heading_t h);
		case (h)
			HEAD_UP: return HEAD_DOWN;
			HEAD_RIGHT: return HEAD_LEFT;
			HEAD_DOWN: return HEAD_UP;
			default: return HEAD_RIGHT;
		endcase
	endfunction

	// True when the next step would leave the playable area
	function automatic logic faces_out(x_t x, y_t y, heading_t h);
		case (h)
			HEAD_UP: return y == TOP_EDGE;
			HEAD_RIGHT: return x == RIGHT_EDGE;
			HEAD_DOWN: return y == BOTTOM_EDGE;
			default: return x == LEFT_EDGE;
		endcase
	endfunction

	function automatic x_t next_x(x_t x, heading_t h);
		if (h == HEAD_RIGHT)
			return x + 8'd1;
		if (h == HEAD_LEFT)
			return x - 8'd1;
		return x;
	endfunction

	function automatic y_t next_y(y_t y, heading_t h);
		if (h == HEAD_DOWN)
			return y + 7'd1;
		if (h == HEAD_UP)
			return y - 7'd1;
		return y;
	endfunction

	task automatic send_code(input logic [7:0] code, input logic make);
		@(negedge clk);
		scan_code = code;
		scan_valid = 1'b1;
		scan_make = make;
		@(negedge clk);
		scan_valid = 1'b0;
		scan_make = 1'b0;
	endtask

	task automatic press_key(input logic [7:0] code);
		send_code(code, 1'b1);
	endtask

	task automatic steer_player(input player_t p, input heading_t h);
		logic [7:0] code;
		case (h)
			HEAD_UP: code = (p == PLAYER_1) ? KEY_P1_UP : KEY_P2_UP;
			HEAD_RIGHT: code = (p == PLAYER_1) ? KEY_P1_RIGHT : KEY_P2_RIGHT;
			HEAD_DOWN: code = (p == PLAYER_1) ? KEY_P1_DOWN : KEY_P2_DOWN;
			default: code = (p == PLAYER_1) ? KEY_P1_LEFT : KEY_P2_LEFT;
		endcase
		press_key(code);
		if (p == PLAYER_1)
			m1_req = h;
		else
			m2_req = h;
	endtask

	task automatic no_plot_for(input int n);
		repeat (n) begin
			@(negedge clk);
			if (plot)
				report_failure("plot strobe seen while the game should be quiet");
		end
	endtask

	task automatic wait_plot(input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (!plot) begin
			n++;
			if (n > PLOT_WAIT)
				report_failure({"timed out waiting for the ", what});
			@(negedge clk);
		end
	endtask

	task automatic check_clear;
		logic first;
		first = 1'b1;
		wait_plot("first clear pixel");
		for (int y = TOP_EDGE; y <= BOTTOM_EDGE; y++) begin
			for (int x = LEFT_EDGE; x <= RIGHT_EDGE; x++) begin
				if (!first)
					@(negedge clk);
				first = 1'b0;
				if (!plot)
					report_failure("clear stream stopped before its last pixel");
				check_xy(plot_x, plot_y, x_t'(x), y_t'(y), "clear pixel");
				check_colour(plot_colour, BG_COLOUR, "clear colour");
			end
		end
		@(negedge clk);
		if (plot)
			report_failure("clear stream ran longer than the playfield");
	endtask

	task automatic draw_heads;
		wait_plot("P1 head plot");
		check_xy(plot_x, plot_y, m1_x, m1_y, "P1 head");
		check_colour(plot_colour, P1_COLOUR, "P1 head colour");
		@(negedge clk);
		if (!plot)
			report_failure("P2 head plot did not follow the P1 head plot");
		check_xy(plot_x, plot_y, m2_x, m2_y, "P2 head");
		check_colour(plot_colour, P2_COLOUR, "P2 head colour");
		trail[m1_x][m1_y] = 1'b1;
		trail[m2_x][m2_y] = 1'b1;
	endtask

	task automatic start_round;
		press_key(KEY_START);
		m1_req = HEAD_RIGHT;
		m2_req = HEAD_LEFT;
		for (int i = 0; i < FIELD_W; i++)
			for (int j = 0; j < FIELD_H; j++)
				trail[i][j] = 1'b0;
		m1_x = P1_START_X;
		m2_x = P2_START_X;
		m1_y = START_Y;
		m2_y = START_Y;
		m1_h = HEAD_RIGHT;
		m2_h = HEAD_LEFT;
		check_clear();
		draw_heads();
	endtask

	// One movement frame of steer, walls, move, trails and draw
	task automatic run_frame(output logic crashed);
		logic w1, w2;
		crashed = 1'b0;
		if (m1_req != reverse_of(m1_h))
			m1_h = m1_req;
		if (m2_req != reverse_of(m2_h))
			m2_h = m2_req;
		w1 = faces_out(m1_x, m1_y, m1_h);
		w2 = faces_out(m2_x, m2_y, m2_h);
		if (w1 || w2) begin
			if (w1)
				m2_score = m2_score + 4'd1;
			if (w2)
				m1_score = m1_score + 4'd1;
			crashed = 1'b1;
		end else begin
			m1_x = next_x(m1_x, m1_h);
			m1_y = next_y(m1_y, m1_h);
			m2_x = next_x(m2_x, m2_h);
			m2_y = next_y(m2_y, m2_h);
			if (trail[m1_x][m1_y]) begin	// P1 checked first
				m2_score = m2_score + 4'd1;
				crashed = 1'b1;
			end else if (trail[m2_x][m2_y]) begin
				m1_score = m1_score + 4'd1;
				crashed = 1'b1;
			end
		end
		if (crashed)
			no_plot_for(PLOT_WAIT);
		else
			draw_heads();
		check_score(p1_score, m1_score, "p1_score");
		check_score(p2_score, m2_score, "p2_score");
	endtask

	task automatic frames_no_crash(input int n);
		logic c;
		repeat (n) begin
			run_frame(c);
			if (c)
				report_failure("a crash happened where the path should be clear");
		end
	endtask

	task automatic test_reset_idle;
		no_plot_for(50);
		check_score(p1_score, 4'd0, "p1_score after reset");
		check_score(p2_score, 4'd0, "p2_score after reset");
	endtask

	task automatic test_start_clear;
		logic [7:0] code;
		logic [7:0] mk;
		for (int i = 0; i < 24; i++) begin
			random_bits(8, code);
			random_bits(1, mk);
			if (mk[0] && code == KEY_START)
				code = code ^ 8'h01;	// Keep junk away from a real start
			send_code(code, mk[0]);
			no_plot_for(2);
		end
		send_code(KEY_START, 1'b0);	// Break of the start key
		no_plot_for(8);
		start_round();
	endtask

	task automatic test_straight;
		frames_no_crash(3);
	endtask

	task automatic test_steering;
		steer_player(PLAYER_1, HEAD_UP);
		frames_no_crash(2);
		steer_player(PLAYER_1, HEAD_LEFT);
		frames_no_crash(2);
		steer_player(PLAYER_2, HEAD_RIGHT);	// Reverse of its heading
		frames_no_crash(2);
	endtask

	task automatic test_wall_crash;
		logic c;
		int n;
		c = 1'b0;
		n = 0;
		steer_player(PLAYER_1, HEAD_UP);
		steer_player(PLAYER_2, HEAD_UP);	// Keeps P2 off P1's old trail
		while (!c && n < MAX_FRAMES) begin
			run_frame(c);
			n++;
		end
		if (!c)
			report_failure("P1 never crashed into the top wall");
		check_score(p1_score, 4'd0, "p1_score after wall crash");
		check_score(p2_score, 4'd1, "p2_score after wall crash");
	endtask

	task automatic test_trail_crash;
		logic c;
		start_round();
		steer_player(PLAYER_2, HEAD_UP);
		frames_no_crash(1);
		steer_player(PLAYER_2, HEAD_LEFT);
		frames_no_crash(35);
		steer_player(PLAYER_2, HEAD_DOWN);	// Into P1's trail on row 60
		run_frame(c);
		if (!c)
			report_failure("P2 did not crash into the P1 trail");
		check_score(p1_score, 4'd1, "p1_score after trail crash");
		check_score(p2_score, 4'd1, "p2_score after trail crash");
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		scan_code = '0;
		scan_valid = 1'b0;
		scan_make = 1'b0;
		lfsr_state = 8'd33;
		m1_score = '0;
		m2_score = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		test_reset_idle();
		test_start_clear();
		test_straight();
		test_steering();
		test_wall_crash();
		test_trail_crash();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/tron_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tron_top (
	input wire clk,
	input wire resetn,
	input wire [7:0] scan_code,
	input wire scan_valid,
	input wire scan_make,
	output logic plot,
	output tron_pkg::x_t plot_x,
	output tron_pkg::y_t plot_y,
	output tron_pkg::colour_t plot_colour,
	output tron_pkg::score_t p1_score,
	output tron_pkg::score_t p2_score
);

	import tron_pkg::*;

	logic start;
	heading_t p1_req, p2_req;
	logic clear_step, place, move, check_walls, check_trail;
	player_t sel;
	x_t clr_x;
	y_t clr_y;
	logic grid_rd, grid_wr;
	logic crash, hit;
	x_t head_x;
	y_t head_y, clear_row;

	key_decode key_decode_i (
		.clk(clk),
		.resetn(resetn),
		.scan_code(scan_code),
		.scan_valid(scan_valid),
		.scan_make(scan_make),
		.start(start),
		.p1_req(p1_req),
		.p2_req(p2_req)
	);

	game_control game_control_i (
		.clk(clk),
		.resetn(resetn),
		.start(start),
		.crash(crash),
		.clear_step(clear_step),
		.place(place),
		.move(move),
		.check_walls(check_walls),
		.check_trail(check_trail),
		.sel(sel),
		.clr_x(clr_x),
		.clr_y(clr_y),
		.grid_rd(grid_rd),
		.grid_wr(grid_wr)
	);

	cycle_mover cycle_mover_i (
		.clk(clk),
		.resetn(resetn),
		.place(place),
		.move(move),
		.check_walls(check_walls),
		.check_trail(check_trail),
		.clear_step(clear_step),
		.grid_wr(grid_wr),
		.hit(hit),
		.sel(sel),
		.clr_x(clr_x),
		.clr_y(clr_y),
		.p1_req(p1_req),
		.p2_req(p2_req),
		.crash(crash),
		.plot(plot),
		.plot_x(plot_x),
		.head_x(head_x),
		.plot_y(plot_y),
		.head_y(head_y),
		.clear_row(clear_row),
		.plot_colour(plot_colour),
		.p1_score(p1_score),
		.p2_score(p2_score)
	);

	trail_grid trail_grid_i (
		.clk(clk),
		.clear_step(clear_step),
		.clear_row(clear_row),
		.grid_rd(grid_rd),
		.grid_wr(grid_wr),
		.head_x(head_x),
		.head_y(head_y),
		.hit(hit)
	);

endmodule

`default_nettype wire

/* verilog/trail_grid.sv */
`timescale 1ns/10ps
`default_nettype none

module trail_grid (
	input wire clk,
	input wire clear_step,
	input wire tron_pkg::y_t clear_row,
	input wire grid_rd,
	input wire grid_wr,
	input wire tron_pkg::x_t head_x,
	input wire tron_pkg::y_t head_y,
	output logic hit
);

	import tron_pkg::*;

	// One bit per cell and a whole row per word
	logic [FIELD_W-1:0] rows [FIELD_H];
	logic [FIELD_W-1:0] head_bit;

	assign head_bit = FIELD_W'(1) << head_x;

	always_ff @(posedge clk) begin
		if (clear_step && (head_x == RIGHT_EDGE))
			rows[clear_row] <= '0;	// Row done on its last pixel
		else if (grid_wr)
			rows[head_y] <= rows[head_y] | head_bit;
	end

	// Occupancy of the head cell is valid next cycle
	always_ff @(posedge clk) begin
		if (grid_rd)
			hit <= |(rows[head_y] & head_bit);
	end

endmodule

`default_nettype wire

/* verilog/cycle_mover.sv */
`timescale 1ns/10ps
`default_nettype none

module cycle_mover (
	input wire clk,
	input wire resetn,
	input wire place,
	input wire move,
	input wire check_walls,
	input wire check_trail,
	input wire clear_step,
	input wire grid_wr,
	input wire hit,
	input wire tron_pkg::player_t sel,
	input wire tron_pkg::x_t clr_x,
	input wire tron_pkg::y_t clr_y,
	input wire tron_pkg::heading_t p1_req,
	input wire tron_pkg::heading_t p2_req,
	output logic crash,
	output logic plot,
	output tron_pkg::x_t plot_x,
	output tron_pkg::x_t head_x,
	output tron_pkg::y_t plot_y,
	output tron_pkg::y_t head_y,
	output tron_pkg::y_t clear_row,
	output tron_pkg::colour_t plot_colour,
	output tron_pkg::score_t p1_score,
	output tron_pkg::score_t p2_score
);

	import tron_pkg::*;

	x_t p1_x, p2_x;
	y_t p1_y, p2_y;
	heading_t p1_head, p2_head;
	logic p1_dead, p2_dead;
	logic p1_wall, p2_wall;

	function automatic heading_t steer(heading_t cur, heading_t req);
		if (req == heading_t'(cur ^ 2'b10))	// No U-turns
			return cur;
		return req;
	endfunction

	function automatic logic at_wall(x_t x, y_t y, heading_t h);
		case (h)
			HEAD_UP: return y == TOP_EDGE;
			HEAD_RIGHT: return x == RIGHT_EDGE;
			HEAD_DOWN: return y == BOTTOM_EDGE;
			default: return x == LEFT_EDGE;
		endcase
	endfunction

	// Heading is committed at the wall check so the check sees the next step
	assign p1_wall = at_wall(p1_x, p1_y, steer(p1_head, p1_req));
	assign p2_wall = at_wall(p2_x, p2_y, steer(p2_head, p2_req));

	assign crash = p1_dead || p2_dead;
	assign head_x = clear_step ? clr_x : (sel == PLAYER_1 ? p1_x : p2_x);	// Grid sees column on clear
	assign head_y = (sel == PLAYER_1) ? p1_y : p2_y;
	assign clear_row = clr_y;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			p1_dead <= 1'b0;
			p2_dead <= 1'b0;
			p1_score <= '0;
			p2_score <= '0;
		end else if (place) begin
			p1_dead <= 1'b0;
			p2_dead <= 1'b0;
		end else if (check_walls) begin
			if (p1_wall) begin
				p1_dead <= 1'b1;
				p2_score <= p2_score + 4'd1;
			end
			if (p2_wall) begin
				p2_dead <= 1'b1;
				p1_score <= p1_score + 4'd1;
			end
		end else if (check_trail && hit) begin
			if (sel == PLAYER_1) begin
				p1_dead <= 1'b1;
				p2_score <= p2_score + 4'd1;
			end else begin
				p2_dead <= 1'b1;
				p1_score <= p1_score + 4'd1;
			end
		end
	end

	// Positions and headings
	always_ff @(posedge clk) begin
		if (place) begin
			p1_x <= P1_START_X;
			p1_y <= START_Y;
			p2_x <= P2_START_X;
			p2_y <= START_Y;
			p1_head <= HEAD_RIGHT;
			p2_head <= HEAD_LEFT;
		end else if (check_walls) begin
			p1_head <= steer(p1_head, p1_req);
			p2_head <= steer(p2_head, p2_req);
		end else if (move) begin
			case (p1_head)
				HEAD_UP: p1_y <= p1_y - 7'd1;
				HEAD_RIGHT: p1_x <= p1_x + 8'd1;
				HEAD_DOWN: p1_y <= p1_y + 7'd1;
				default: p1_x <= p1_x - 8'd1;
			endcase
			case (p2_head)
				HEAD_UP: p2_y <= p2_y - 7'd1;
				HEAD_RIGHT: p2_x <= p2_x + 8'd1;
				HEAD_DOWN: p2_y <= p2_y + 7'd1;
				default: p2_x <= p2_x - 8'd1;
			endcase
		end
	end

	// Pixel stream
	always_ff @(posedge clk) begin
		if (!resetn)
			plot <= 1'b0;
		else
			plot <= clear_step || grid_wr;
	end

	always_ff @(posedge clk) begin
		if (clear_step) begin
			plot_x <= clr_x;
			plot_y <= clr_y;
			plot_colour <= BG_COLOUR;
		end else if (grid_wr) begin
			plot_x <= head_x;
			plot_y <= head_y;
			plot_colour <= (sel == PLAYER_1) ? P1_COLOUR : P2_COLOUR;
		end
	end

	a_plot_in_field: assert property (
		@(posedge clk) disable iff (!resetn)
		plot |-> (plot_x >= LEFT_EDGE) && (plot_x <= RIGHT_EDGE)
			&& (plot_y >= TOP_EDGE) && (plot_y <= BOTTOM_EDGE));

endmodule

`default_nettype wire

/* verilog/game_control.sv */
`timescale 1ns/10ps
`default_nettype none

module game_control (
	input wire clk,
	input wire resetn,
	input wire start,
	input wire crash,
	output logic clear_step,
	output logic place,
	output logic move,
	output logic check_walls,
	output logic check_trail,
	output tron_pkg::player_t sel,
	output tron_pkg::x_t clr_x,
	output tron_pkg::y_t clr_y,
	output logic grid_rd,
	output logic grid_wr
);

	import tron_pkg::*;

	state_t state, next_state;
	logic [WAIT_W-1:0] wait_cnt;
	logic clr_last;

	assign clr_last = (clr_x == RIGHT_EDGE) && (clr_y == BOTTOM_EDGE);

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: if (start) next_state = ST_CLEAR;
			ST_CLEAR: if (clr_last) next_state = ST_PLACE;
			ST_PLACE: next_state = ST_DRAW_P1;
			ST_DRAW_P1: next_state = crash ? ST_IDLE : ST_DRAW_P2;	// After P2 trail check
			ST_DRAW_P2: next_state = ST_WAIT;
			ST_WAIT: if (wait_cnt == WAIT_W'(FRAME_TICKS - 1)) next_state = ST_WALLS;
			ST_WALLS: next_state = ST_MOVE;
			ST_MOVE: next_state = crash ? ST_IDLE : ST_READ_P1;	// After wall check
			ST_READ_P1: next_state = ST_CHECK_P1;
			ST_CHECK_P1: next_state = ST_READ_P2;
			ST_READ_P2: next_state = crash ? ST_IDLE : ST_CHECK_P2;	// After P1 trail check
			ST_CHECK_P2: next_state = ST_DRAW_P1;
			default: next_state = ST_IDLE;
		endcase
	end

	// Strobes decode from state; a pending crash suppresses the step it would start
	always_comb begin
		clear_step = (state == ST_CLEAR);
		place = (state == ST_PLACE);
		check_walls = (state == ST_WALLS);
		move = (state == ST_MOVE) && !crash;
		check_trail = (state == ST_CHECK_P1) || (state == ST_CHECK_P2);
		grid_rd = (state == ST_READ_P1) || ((state == ST_READ_P2) && !crash);
		grid_wr = ((state == ST_DRAW_P1) && !crash) || (state == ST_DRAW_P2);
		case (state)
			ST_DRAW_P2, ST_READ_P2, ST_CHECK_P2: sel = PLAYER_2;
			default: sel = PLAYER_1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= ST_IDLE;
			clr_x <= LEFT_EDGE;
			clr_y <= TOP_EDGE;
			wait_cnt <= '0;
		end else begin
			state <= next_state;
			// Raster scan with x running fastest that wraps to the corner for the next round
			if (state == ST_CLEAR) begin
				if (clr_x == RIGHT_EDGE) begin
					clr_x <= LEFT_EDGE;
					clr_y <= (clr_y == BOTTOM_EDGE) ? TOP_EDGE : clr_y + 7'd1;
				end else begin
					clr_x <= clr_x + 8'd1;
				end
			end
			wait_cnt <= (state == ST_WAIT) ? wait_cnt + 1'b1 : '0;
		end
	end

	// Walls are checked the cycle before a move, never alongside it
	a_move_after_walls: assert property (
		@(posedge clk) disable iff (!resetn) move |-> $past(check_walls));

	// A crashed round draws nothing more
	a_no_draw_after_crash: assert property (
		@(posedge clk) disable iff (!resetn) grid_wr |-> !crash);

endmodule

`default_nettype wire

/* verilog/key_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module key_decode (
	input wire clk,
	input wire resetn,
	input wire [7:0] scan_code,
	input wire scan_valid,
	input wire scan_make,
	output logic start,
	output tron_pkg::heading_t p1_req,
	output tron_pkg::heading_t p2_req
);

	import tron_pkg::*;

	logic key_event;

	// Break codes are ignored
	assign key_event = scan_valid && scan_make;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			start <= 1'b0;
			p1_req <= HEAD_RIGHT;
			p2_req <= HEAD_LEFT;
		end else begin
			start <= key_event && (scan_code == KEY_START);
			if (key_event) begin
				case (scan_code)
					KEY_START: begin	// New round reloads the default headings
						p1_req <= HEAD_RIGHT;
						p2_req <= HEAD_LEFT;
					end
					KEY_P1_UP: p1_req <= HEAD_UP;
					KEY_P1_RIGHT: p1_req <= HEAD_RIGHT;
					KEY_P1_DOWN: p1_req <= HEAD_DOWN;
					KEY_P1_LEFT: p1_req <= HEAD_LEFT;
					KEY_P2_UP: p2_req <= HEAD_UP;
					KEY_P2_RIGHT: p2_req <= HEAD_RIGHT;
					KEY_P2_DOWN: p2_req <= HEAD_DOWN;
					KEY_P2_LEFT: p2_req <= HEAD_LEFT;
					default: ;	// Other keys change nothing
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/tron_pkg.sv */
`default_nettype none

package tron_pkg;

	typedef logic [7:0] x_t;	// Column
	typedef logic [6:0] y_t;	// Row
	typedef logic [2:0] colour_t;
	typedef logic [3:0] score_t;	// Wraps at 16

	// Encoding gives each reverse heading as the XOR with 2'b10
	typedef enum logic [1:0] {
		HEAD_UP,
		HEAD_RIGHT,
		HEAD_DOWN,
		HEAD_LEFT
	} heading_t;

	typedef enum logic {
		PLAYER_1,
		PLAYER_2
	} player_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_PLACE,
		ST_DRAW_P1,
		ST_DRAW_P2,
		ST_WAIT,
		ST_WALLS,
		ST_MOVE,
		ST_READ_P1,
		ST_CHECK_P1,
		ST_READ_P2,
		ST_CHECK_P2
	} state_t;

	// Field geometry
	localparam int FIELD_W = 160;
	localparam int FIELD_H = 120;
	localparam x_t LEFT_EDGE = 8'd1;
	localparam x_t RIGHT_EDGE = 8'd158;
	localparam y_t TOP_EDGE = 7'd1;
	localparam y_t BOTTOM_EDGE = 7'd118;

	localparam x_t P1_START_X = 8'd40;
	localparam x_t P2_START_X = 8'd100;
	localparam y_t START_Y = 7'd60;

	localparam colour_t BG_COLOUR = 3'd0;
	localparam colour_t P1_COLOUR = 3'd2;
	localparam colour_t P2_COLOUR = 3'd3;

	// Keyboard make codes
	localparam logic [7:0] KEY_START = 8'h29;
	localparam logic [7:0] KEY_P1_UP = 8'h1D;
	localparam logic [7:0] KEY_P1_RIGHT = 8'h23;
	localparam logic [7:0] KEY_P1_DOWN = 8'h1B;
	localparam logic [7:0] KEY_P1_LEFT = 8'h1C;
	localparam logic [7:0] KEY_P2_UP = 8'h75;
	localparam logic [7:0] KEY_P2_RIGHT = 8'h74;
	localparam logic [7:0] KEY_P2_DOWN = 8'h72;
	localparam logic [7:0] KEY_P2_LEFT = 8'h6B;

	// Scaled down from the 60 Hz board tick
	localparam int FRAME_TICKS = 64;
	localparam int WAIT_W = $clog2(FRAME_TICKS);

endpackage

`default_nettype wire
